// ==== logic/exec_pkg.sv ====
// exec package with widths, queue depth and the ALU and operand select encodings
package exec_pkg;

    // datapath width, RV32
    localparam int xlen = 32;

    // reorder buffer tag width
    localparam int tag_width = 5;

    // completion queue entries
    localparam int queue_depth = 4;

    // filler for an undefined ALU function
    localparam logic [xlen-1:0] unknown_result = 32'hdead_beef;

    // ALU function codes
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_slt  = 4'h3,
        alu_sltu = 4'h4,
        alu_or   = 4'h5,
        alu_xor  = 4'h6,
        alu_srl  = 4'h7,
        alu_sll  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_t;

    // operand A sources
    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_npc  = 2'h1,
        opa_is_pc   = 2'h2,
        opa_is_zero = 2'h3
    } opa_select_t;

    // operand B sources
    // immediates are decoded from the instruction word
    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } opb_select_t;

endpackage

// ==== logic/alu.sv ====
// alu computes the RV32I arithmetic, logic, compare and shift functions
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  logic [xlen-1:0] opa,
    input  logic [xlen-1:0] opb,
    input  alu_func_t       func,
    output logic [xlen-1:0] result
);

    // signed views for slt and sra
    logic signed [xlen-1:0] signed_opa;
    logic signed [xlen-1:0] signed_opb;
    logic                   lt_signed;
    logic                   lt_unsigned;
    // only the low five bits shift
    logic [4:0]             shamt;

    assign signed_opa  = opa;
    assign signed_opb  = opb;
    assign lt_signed   = signed_opa < signed_opb;
    assign lt_unsigned = opa < opb;
    assign shamt       = opb[4:0];

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            // compares give 0 or 1
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_srl:  result = opa >> shamt;
            alu_sll:  result = opa << shamt;
            // sign bit fills from the left
            alu_sra:  result = signed_opa >>> shamt;
            default:  result = unknown_result;
        endcase
    end

endmodule

// ==== logic/branch_compare.sv ====
// branch_compare evaluates the six RV32I conditional branch conditions
`timescale 1ns/1ps

module branch_compare import exec_pkg::*; (
    // funct3 of the branch
    input  logic [2:0]      func,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    output logic            take
);

    logic signed [xlen-1:0] signed_rs1;
    logic signed [xlen-1:0] signed_rs2;

    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (func)
            3'b000:  take = rs1 == rs2;                // beq
            3'b001:  take = rs1 != rs2;                // bne
            3'b100:  take = signed_rs1 < signed_rs2;   // blt
            3'b101:  take = signed_rs1 >= signed_rs2;  // bge
            3'b110:  take = rs1 < rs2;                 // bltu
            3'b111:  take = rs1 >= rs2;                // bgeu
            // codes 2 and 3 are no branch
            default: take = 1'b0;
        endcase
    end

endmodule

// ==== logic/alu_fu.sv ====
// alu_fu selects operands, runs the ALU and branch compare, and holds the result until ack
`timescale 1ns/1ps

module alu_fu import exec_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  logic [31:0]          inst,
    input  logic [xlen-1:0]      rs1_value,
    input  logic [xlen-1:0]      rs2_value,
    input  logic [xlen-1:0]      pc,
    input  logic [xlen-1:0]      npc,
    input  logic [tag_width-1:0] tag,
    input  alu_func_t            alu_func,
    input  opa_select_t          opa_select,
    input  opb_select_t          opb_select,
    input  logic                 ack,
    output logic                 issue_ready,
    output logic                 done,
    output logic [xlen-1:0]      result_value,
    output logic [tag_width-1:0] result_tag,
    output logic                 result_take
);

    logic [xlen-1:0] opa_mux_out;
    logic [xlen-1:0] opb_mux_out;
    logic [xlen-1:0] alu_result;
    logic            take_conditional;

    // sign-extended immediates, RV32I layout
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    assign i_imm = {{(xlen-11){inst[31]}}, inst[30:20]};
    assign s_imm = {{(xlen-11){inst[31]}}, inst[30:25], inst[11:7]};
    // b and j immediates have an implied zero lsb
    assign b_imm = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // operand A
    always_comb begin
        case (opa_select)
            opa_is_rs1:  opa_mux_out = rs1_value;
            opa_is_npc:  opa_mux_out = npc;
            opa_is_pc:   opa_mux_out = pc;
            opa_is_zero: opa_mux_out = '0;
            default:     opa_mux_out = '0;
        endcase
    end

    // operand B
    always_comb begin
        case (opb_select)
            opb_is_rs2:   opb_mux_out = rs2_value;
            opb_is_i_imm: opb_mux_out = i_imm;
            opb_is_s_imm: opb_mux_out = s_imm;
            opb_is_b_imm: opb_mux_out = b_imm;
            opb_is_u_imm: opb_mux_out = u_imm;
            opb_is_j_imm: opb_mux_out = j_imm;
            // codes 6 and 7 unused
            default:      opb_mux_out = unknown_result;
        endcase
    end

    alu i_alu (
        .opa    (opa_mux_out),
        .opb    (opb_mux_out),
        .func   (alu_func),
        .result (alu_result)
    );

    // branch compares the raw register values, funct3 picks the condition
    branch_compare i_branch_compare (
        .func (inst[14:12]),
        .rs1  (rs1_value),
        .rs2  (rs2_value),
        .take (take_conditional)
    );

    // stalled while a result waits without ack
    assign issue_ready = !done || ack;

    // result payload, loaded only at issue
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result_value <= alu_result;
            result_tag   <= tag;
            result_take  <= take_conditional;
        end
    end

    // done set by issue, cleared by ack
    // a same-edge issue wins over the clear
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (issue_valid) begin
            done <= 1'b1;
        end else if (ack) begin
            done <= 1'b0;
        end
    end

endmodule

// ==== logic/completion_queue.sv ====
// completion_queue buffers finished results in issue order and acks the FU while it has room
`timescale 1ns/1ps

module completion_queue import exec_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 done,
    input  logic [xlen-1:0]      result_value,
    input  logic [tag_width-1:0] result_tag,
    input  logic                 result_take,
    input  logic                 pop,
    output logic                 ack,
    output logic                 empty,
    output logic [xlen-1:0]      head_value,
    output logic [tag_width-1:0] head_tag,
    output logic                 head_take
);

    localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_width = $clog2(queue_depth + 1);

    // entry storage
    logic [xlen-1:0]      value_mem [queue_depth];
    logic [tag_width-1:0] tag_mem   [queue_depth];
    logic                 take_mem  [queue_depth];

    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   full;
    logic                   do_pop;

    assign full   = count == count_width'(queue_depth);
    assign empty  = count == '0;
    assign ack    = done && !full;
    // pop of an empty queue is ignored
    assign do_pop = pop && !empty;

    // oldest entry
    assign head_value = value_mem[rd_ptr];
    assign head_tag   = tag_mem[rd_ptr];
    assign head_take  = take_mem[rd_ptr];

    // write at the end of the ack cycle
    always_ff @(posedge clock) begin
        if (ack) begin
            value_mem[wr_ptr] <= result_value;
            tag_mem[wr_ptr]   <= result_tag;
            take_mem[wr_ptr]  <= result_take;
        end
    end

    // pointers wrap at queue_depth
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ack) begin
                wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // write and pop together leave count alone
            if (ack && !do_pop) begin
                count <= count + 1'b1;
            end else if (!ack && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/cdb_driver.sv ====
// cdb_driver holds the oldest result on the CDB until the bus grants it
`timescale 1ns/1ps

module cdb_driver import exec_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 empty,
    input  logic [xlen-1:0]      head_value,
    input  logic [tag_width-1:0] head_tag,
    input  logic                 head_take,
    input  logic                 cdb_grant,
    output logic                 pop,
    output logic                 cdb_valid,
    output logic [xlen-1:0]      cdb_value,
    output logic [tag_width-1:0] cdb_tag,
    output logic                 cdb_take_branch
);

    // register free, or emptied by this cycle's grant
    assign pop = !empty && (!cdb_valid || cdb_grant);

    // payload changes only on a load
    always_ff @(posedge clock) begin
        if (pop) begin
            cdb_value       <= head_value;
            cdb_tag         <= head_tag;
            cdb_take_branch <= head_take;
        end
    end

    // valid stays up until granted
    // a granted result can be replaced at the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else if (pop) begin
            cdb_valid <= 1'b1;
        end else if (cdb_grant) begin
            cdb_valid <= 1'b0;
        end
    end

endmodule

// ==== logic/exec_unit.sv ====
// exec_unit top level of the integer execute slice, FU into completion queue into CDB
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    // issue side
    input  logic                 issue_valid,
    input  logic [31:0]          inst,
    input  logic [xlen-1:0]      rs1_value,
    input  logic [xlen-1:0]      rs2_value,
    input  logic [xlen-1:0]      pc,
    input  logic [xlen-1:0]      npc,
    input  logic [tag_width-1:0] tag,
    input  alu_func_t            alu_func,
    input  opa_select_t          opa_select,
    input  opb_select_t          opb_select,
    output logic                 issue_ready,
    // cdb side
    output logic                 cdb_valid,
    output logic [xlen-1:0]      cdb_value,
    output logic [tag_width-1:0] cdb_tag,
    output logic                 cdb_take_branch,
    input  logic                 cdb_grant
);

    // fu to queue
    logic                 done;
    logic                 ack;
    logic [xlen-1:0]      result_value;
    logic [tag_width-1:0] result_tag;
    logic                 result_take;

    // queue to driver
    logic                 empty;
    logic                 pop;
    logic [xlen-1:0]      head_value;
    logic [tag_width-1:0] head_tag;
    logic                 head_take;

    alu_fu i_alu_fu (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .inst         (inst),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .pc           (pc),
        .npc          (npc),
        .tag          (tag),
        .alu_func     (alu_func),
        .opa_select   (opa_select),
        .opb_select   (opb_select),
        .ack          (ack),
        .issue_ready  (issue_ready),
        .done         (done),
        .result_value (result_value),
        .result_tag   (result_tag),
        .result_take  (result_take)
    );

    completion_queue i_completion_queue (
        .clock        (clock),
        .reset        (reset),
        .done         (done),
        .result_value (result_value),
        .result_tag   (result_tag),
        .result_take  (result_take),
        .pop          (pop),
        .ack          (ack),
        .empty        (empty),
        .head_value   (head_value),
        .head_tag     (head_tag),
        .head_take    (head_take)
    );

    cdb_driver i_cdb_driver (
        .clock           (clock),
        .reset           (reset),
        .empty           (empty),
        .head_value      (head_value),
        .head_tag        (head_tag),
        .head_take       (head_take),
        .cdb_grant       (cdb_grant),
        .pop             (pop),
        .cdb_valid       (cdb_valid),
        .cdb_value       (cdb_value),
        .cdb_tag         (cdb_tag),
        .cdb_take_branch (cdb_take_branch)
    );

endmodule

// ==== tests/exec_unit_assert.sv ====
// exec_unit_assert checks the issue and CDB handshakes and queue overflow of the execute slice
`timescale 1ns/1ps

module exec_unit_assert import exec_pkg::*; (
    input logic                 clock,
    input logic                 reset,
    input logic                 issue_valid,
    input logic                 issue_ready,
    input logic                 done,
    input logic                 ack,
    input logic                 pop,
    input logic                 empty,
    input logic                 cdb_valid,
    input logic [xlen-1:0]      cdb_value,
    input logic [tag_width-1:0] cdb_tag,
    input logic                 cdb_take_branch,
    input logic                 cdb_grant
);

    // queue occupancy rebuilt from its handshakes
    int queued;

    always_ff @(posedge clock) begin
        if (reset) begin
            queued <= 0;
        end else begin
            queued <= queued + int'(ack) - int'(pop && !empty);
        end
    end

    // issuer waits for issue_ready
    assert property (@(posedge clock) disable iff (reset) issue_valid |-> issue_ready)
        else $error("issue_valid while issue_ready is low");

    // held result stays put until granted
    assert property (@(posedge clock) disable iff (reset)
        cdb_valid && !cdb_grant |=> cdb_valid && $stable(cdb_value) && $stable(cdb_tag)
            && $stable(cdb_take_branch))
        else $error("CDB result changed without a grant");

    assert property (@(posedge clock) reset |=> !cdb_valid)
        else $error("cdb_valid high in the cycle after reset");

    // no write into a full queue
    assert property (@(posedge clock) disable iff (reset) queued == queue_depth |-> !(done && ack))
        else $error("write accepted while the queue is full");

endmodule

bind exec_unit exec_unit_assert i_exec_unit_assert (.*);

// ==== tests/exec_unit_tb.sv ====
// exec_unit_tb issues vectors from a file and checks every result that leaves on the CDB
`timescale 1ns/1ps

module exec_unit_tb import exec_pkg::*; ();

    localparam int max_tests     = 32;
    localparam int ready_timeout = 50;
    localparam int drain_timeout = 500;
    // driver register, queue entries and the FU result
    localparam int backlog       = queue_depth + 2;

    logic                 clock;
    logic                 reset;
    logic                 issue_valid;
    logic [31:0]          inst;
    logic [xlen-1:0]      rs1_value;
    logic [xlen-1:0]      rs2_value;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      npc;
    logic [tag_width-1:0] tag;
    alu_func_t            alu_func;
    opa_select_t          opa_select;
    opb_select_t          opb_select;
    logic                 issue_ready;
    logic                 cdb_valid;
    logic [xlen-1:0]      cdb_value;
    logic [tag_width-1:0] cdb_tag;
    logic                 cdb_take_branch;
    logic                 cdb_grant;

    // vector columns inst rs1 rs2 pc npc func opa opb value take
    string       vec_name [max_tests];
    logic [31:0] vec      [max_tests][10];
    int          num_tests;

    // issued test indices, oldest first
    int   expect_q [$];
    int   pass_count;
    int   error_count;
    logic hold_grant;

    exec_unit i_exec_unit (.*);

    always #5 clock = ~clock;

    task automatic load_vectors();
        int    fd;
        int    fields;
        string line;
        string name;
        num_tests = 0;
        fd = $fopen("tests/exec_unit_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/exec_unit_input.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && num_tests < max_tests) begin
                line = "";
                void'($fgets(line, fd));
                // column notes start with a hash
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %d %d %d %h %d", name,
                        vec[num_tests][0], vec[num_tests][1], vec[num_tests][2],
                        vec[num_tests][3], vec[num_tests][4], vec[num_tests][5],
                        vec[num_tests][6], vec[num_tests][7], vec[num_tests][8],
                        vec[num_tests][9]);
                    if (fields == 11) begin
                        vec_name[num_tests] = name;
                        num_tests++;
                    end else begin
                        $display("malformed vector line after test %0d", num_tests);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("no test vectors found in tests/exec_unit_input.txt");
                error_count++;
            end
        end
    endtask

    // one strobe once issue_ready allows it
    task automatic issue_vector(input int idx);
        int waited;
        waited = 0;
        while (!issue_ready && waited < ready_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (!issue_ready) begin
            $display("issue_ready never came back before test %s", vec_name[idx]);
            error_count++;
        end else begin
            inst        = vec[idx][0];
            rs1_value   = vec[idx][1];
            rs2_value   = vec[idx][2];
            pc          = vec[idx][3];
            npc         = vec[idx][4];
            alu_func    = alu_func_t'(vec[idx][5][3:0]);
            opa_select  = opa_select_t'(vec[idx][6][1:0]);
            opb_select  = opb_select_t'(vec[idx][7][2:0]);
            // tag is the test index
            tag         = tag_width'(idx);
            issue_valid = 1'b1;
            expect_q.push_back(idx);
            @(negedge clock);
            issue_valid = 1'b0;
        end
    endtask

    // full backlog with no grant must stall the issuer
    task automatic check_stalled(input int base);
        int waited;
        waited = 0;
        while (issue_ready && waited < ready_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (issue_ready) begin
            $display("issue_ready stayed high with %0d results held from test %s",
                backlog, vec_name[base]);
            error_count++;
        end else begin
            $display("ok stall_%0d: issue_ready low with %0d results held", base, backlog);
            pass_count++;
        end
    endtask

    task automatic wait_drained(input string phase);
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < drain_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("%s phase timed out with %0d results missing", phase, expect_q.size());
            error_count++;
        end
    endtask

    // compare the granted result with the oldest issued test
    function automatic void check_result();
        int idx;
        if (expect_q.size() == 0) begin
            $display("unexpected CDB result with tag %0d", cdb_tag);
            error_count++;
        end else begin
            idx = expect_q.pop_front();
            if (cdb_tag !== tag_width'(idx) || cdb_value !== vec[idx][8]
                    || cdb_take_branch !== vec[idx][9][0]) begin
                $display("** Error %s: expected tag/value/take %0d %h %0d, actual %0d %h %0d",
                    vec_name[idx], idx, vec[idx][8], vec[idx][9][0],
                    cdb_tag, cdb_value, cdb_take_branch);
                error_count++;
            end else begin
                $display("ok %s: tag %0d value %h take %0d",
                    vec_name[idx], cdb_tag, cdb_value, cdb_take_branch);
                pass_count++;
            end
        end
    endfunction

    // grant source and CDB monitor
    initial begin
        cdb_grant = 1'b0;
        forever begin
            @(negedge clock);
            if (hold_grant) begin
                cdb_grant = 1'b0;
            end else begin
                cdb_grant = ($urandom % 4) != 0;
            end
            // transfer happens at the coming rising edge
            if (cdb_valid && cdb_grant) begin
                check_result();
            end
        end
    end

    initial begin
        void'($urandom(32'h6ce2));
        clock       = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        inst        = '0;
        rs1_value   = '0;
        rs2_value   = '0;
        pc          = '0;
        npc         = '0;
        tag         = '0;
        alu_func    = alu_add;
        opa_select  = opa_is_rs1;
        opb_select  = opb_is_rs2;
        hold_grant  = 1'b1;
        pass_count  = 0;
        error_count = 0;
        load_vectors();
        repeat (10) @(negedge clock);
        reset = 1'b0;
        hold_grant <= 1'b0;
        @(negedge clock);
        // idle state out of reset
        if (cdb_valid !== 1'b0 || issue_ready !== 1'b1) begin
            $display("** Error reset: expected cdb_valid 0 issue_ready 1, actual %b %b",
                cdb_valid, issue_ready);
            error_count++;
        end else begin
            $display("ok reset: cdb_valid 0 issue_ready 1");
            pass_count++;
        end
        // back to back issue under random grants
        for (int i = 0; i < num_tests; i++) begin
            issue_vector(i);
        end
        wait_drained("random grant");
        // groups that fill every stage while grant is low
        for (int base = 0; base < num_tests; base += backlog) begin
            hold_grant <= 1'b1;
            for (int i = base; i < base + backlog && i < num_tests; i++) begin
                issue_vector(i);
            end
            if (base + backlog <= num_tests) begin
                check_stalled(base);
            end
            hold_grant <= 1'b0;
            wait_drained("held grant");
        end
        // late or duplicate results would show here
        repeat (20) @(negedge clock);
        $display("%0d checks passed, %0d errors", pass_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tests/exec_unit_input.txt ====
# name inst rs1 rs2 pc npc func opa opb expected_value expected_take
# hex columns: inst rs1 rs2 pc npc expected_value; decimal: func opa opb expected_take
alu_add   00002033 7fffffff 00000001 00000000 00000004 0 0 0 80000000 0
alu_sub   00002033 00000005 00000007 00000000 00000004 1 0 0 fffffffe 0
alu_and   00002033 f0f0f0f0 ff00ff00 00000000 00000004 2 0 0 f000f000 0
alu_slt   00002033 fffffffe 00000001 00000000 00000004 3 0 0 00000001 0
alu_sltu  00002033 fffffffe 00000001 00000000 00000004 4 0 0 00000000 0
alu_or    00002033 f0f0f0f0 0f0f0000 00000000 00000004 5 0 0 fffff0f0 0
alu_xor   00002033 ff00ff00 0ff00ff0 00000000 00000004 6 0 0 f0f0f0f0 0
alu_srl   00002033 80000010 00000024 00000000 00000004 7 0 0 08000001 0
alu_sll   00002033 00000081 00000003 00000000 00000004 8 0 0 00000408 0
alu_sra   00002033 80000010 00000004 00000000 00000004 9 0 0 f8000001 0
opa_pc    00002033 00000000 00000004 00001000 00001004 0 2 0 00001004 0
opa_npc   00002033 00000000 00000010 00001000 00001004 0 1 0 00001014 0
imm_i_pos 12302000 00000000 00000000 00000000 00000004 0 3 1 00000123 0
imm_i_neg 80002000 00000000 00000000 00000000 00000004 0 3 1 fffff800 0
imm_s_pos 2a002280 00000000 00000000 00000000 00000004 0 3 2 000002a5 0
imm_s_neg fe002f80 00000000 00000000 00000000 00000004 0 3 2 ffffffff 0
imm_b_pos 02002280 00000000 00000000 00000000 00000004 0 3 3 00000824 0
imm_b_neg 80002000 00000000 00000000 00000000 00000004 0 3 3 fffff000 0
imm_u_pos 12342000 00000000 00000000 00000000 00000004 0 3 4 12342000 0
imm_u_neg abcda000 00000000 00000000 00000000 00000004 0 3 4 abcda000 0
imm_j_pos 00302000 00000000 00000000 00000000 00000004 0 3 5 00002802 0
imm_j_neg 80002000 00000000 00000000 00000000 00000004 0 3 5 fff02000 0
br_beq    00000063 00000005 00000005 00000000 00000004 0 0 0 0000000a 1
br_bne    00001063 00000005 00000005 00000000 00000004 0 0 0 0000000a 0
br_blt    00004063 fffffffe 00000001 00000000 00000004 0 0 0 ffffffff 1
br_bge    00005063 fffffffe 00000001 00000000 00000004 0 0 0 ffffffff 0
br_bltu   00006063 fffffffe 00000001 00000000 00000004 0 0 0 ffffffff 0
br_bgeu   00007063 fffffffe 00000001 00000000 00000004 0 0 0 ffffffff 1
br_code2  00002063 00000005 00000005 00000000 00000004 0 0 0 0000000a 0
br_code3  00003063 00000005 00000005 00000000 00000004 0 0 0 0000000a 0

// ==== flist.f ====
logic/exec_pkg.sv
logic/alu.sv
logic/branch_compare.sv
logic/alu_fu.sv
logic/completion_queue.sv
logic/cdb_driver.sv
logic/exec_unit.sv
tests/exec_unit_assert.sv
tests/exec_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the exec_unit testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module exec_unit_tb -f flist.f -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0
